// ==== design/dcache_geom_pkg.sv ====
`default_nettype none

package dcache_geom_pkg;

	// the per-set LRU bit only works for two ways
	localparam int WAYS = 2;
	localparam int SETS = 8;
	localparam int INDEX_W = 3;

	localparam int BLOCK_W = 64;

	// block address, 512 blocks
	localparam int ADDR_W = 9;
	localparam int TAG_W = ADDR_W - INDEX_W;

	// tag 0 means no transaction
	localparam int MEM_TAG_W = 4;

	// accepted load to completion, in cycles
	localparam int MEM_LATENCY = 8;

endpackage

`default_nettype wire

// ==== design/dcache_bus_pkg.sv ====
`default_nettype none

package dcache_bus_pkg;

	// processor side
	typedef struct packed {
		logic                                write;
		logic [dcache_geom_pkg::ADDR_W-1:0]  addr;
		logic [dcache_geom_pkg::BLOCK_W-1:0] data;
	} cpu_req_t;

	typedef struct packed {
		logic [dcache_geom_pkg::BLOCK_W-1:0] data;
	} cpu_resp_t;

	// memory side
	typedef enum logic [1:0] {
		MEM_NONE  = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_kind_e;

	typedef struct packed {
		mem_kind_e                           kind;
		logic [dcache_geom_pkg::ADDR_W-1:0]  addr;
		logic [dcache_geom_pkg::BLOCK_W-1:0] data;
	} mem_cmd_t;

	typedef logic [dcache_geom_pkg::MEM_TAG_W-1:0] mem_tag_t;

endpackage

`default_nettype wire

// ==== design/dcache_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_mem (
	input  wire logic                                  clock,
	input  wire logic                                  reset,
	input  wire logic [dcache_geom_pkg::INDEX_W-1:0]   index_in,
	input  wire logic [dcache_geom_pkg::TAG_W-1:0]     tag_in,
	input  wire logic                                  read_enable,
	input  wire logic                                  write_enable,
	input  wire logic [dcache_geom_pkg::BLOCK_W-1:0]   write_data_in,
	input  wire dcache_bus_pkg::mem_tag_t              mem_response,
	input  wire dcache_bus_pkg::mem_tag_t              mem_tag,
	input  wire logic [dcache_geom_pkg::BLOCK_W-1:0]   load_data_in,
	output logic [dcache_geom_pkg::BLOCK_W-1:0]        store_data_out,
	output logic [dcache_geom_pkg::TAG_W-1:0]          victim_tag,
	output logic                                       data_is_valid,
	output logic                                       data_is_dirty,
	output logic                                       data_is_miss,
	output logic                                       cache_is_full,
	output logic [dcache_geom_pkg::BLOCK_W-1:0]        data_out
);

	// block storage
	logic [dcache_geom_pkg::BLOCK_W-1:0] data_q [dcache_geom_pkg::SETS][dcache_geom_pkg::WAYS];
	logic [dcache_geom_pkg::SETS-1:0][dcache_geom_pkg::WAYS-1:0][dcache_geom_pkg::TAG_W-1:0] tag_q;

	// line state
	logic [dcache_geom_pkg::SETS-1:0][dcache_geom_pkg::WAYS-1:0] valid_q;
	logic [dcache_geom_pkg::SETS-1:0][dcache_geom_pkg::WAYS-1:0] dirty_q;
	logic [dcache_geom_pkg::SETS-1:0][dcache_geom_pkg::WAYS-1:0] fill_is_load_q;
	dcache_bus_pkg::mem_tag_t [dcache_geom_pkg::SETS-1:0][dcache_geom_pkg::WAYS-1:0] pending_q;

	// one bit per set, points at the least recently used way
	logic [dcache_geom_pkg::SETS-1:0] lru_q;

	logic                                lookup;
	logic [dcache_geom_pkg::WAYS-1:0]    hit_vec;
	logic                                hit;
	logic                                hit_way;
	logic                                victim;
	logic                                miss;
	logic                                dirty_miss;
	logic                                clean_miss;
	logic [dcache_geom_pkg::SETS-1:0][dcache_geom_pkg::WAYS-1:0] fill_hit;
	logic [dcache_geom_pkg::BLOCK_W-1:0] read_data;

	assign lookup = read_enable | write_enable;
	assign victim = lru_q[index_in];

	always_comb
	begin
		for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
		begin
			hit_vec[w] = valid_q[index_in][w] && (tag_q[index_in][w] == tag_in);
		end
	end

	assign hit = |hit_vec;
	assign hit_way = hit_vec[1];

	// miss classification against the LRU victim
	assign miss = lookup && !hit;
	assign cache_is_full = miss && (pending_q[index_in][victim] != '0);
	assign dirty_miss = miss && !cache_is_full && dirty_q[index_in][victim];
	assign clean_miss = miss && !cache_is_full && !dirty_q[index_in][victim];

	assign data_is_valid = lookup && hit;
	assign data_is_miss = miss;
	assign data_is_dirty = dirty_miss;
	assign victim_tag = tag_q[index_in][victim];
	assign store_data_out = dirty_miss ? data_q[index_in][victim] : '0;

	// completion broadcast against every pending way
	always_comb
	begin
		for (int s = 0; s < dcache_geom_pkg::SETS; s++)
		begin
			for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
			begin
				fill_hit[s][w] = (mem_tag != '0) && (pending_q[s][w] == mem_tag);
			end
		end
	end

	always_comb
	begin
		read_data = data_out;
		if (lookup && hit)
		begin
			read_data = write_enable ? write_data_in : data_q[index_in][hit_way];
		end
		for (int s = 0; s < dcache_geom_pkg::SETS; s++)
		begin
			for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
			begin
				if (fill_hit[s][w])
				begin
					read_data = fill_is_load_q[s][w] ? load_data_in : write_data_in;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid_q <= '0;
			dirty_q <= '0;
			fill_is_load_q <= '0;
			pending_q <= '0;
			lru_q <= '0;
		end
		else
		begin
			for (int s = 0; s < dcache_geom_pkg::SETS; s++)
			begin
				for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
				begin
					if (fill_hit[s][w])
					begin
						valid_q[s][w] <= 1'b1;
						// a write miss lands dirty
						dirty_q[s][w] <= !fill_is_load_q[s][w];
						pending_q[s][w] <= '0;
					end
				end
			end

			if (lookup && hit)
			begin
				lru_q[index_in] <= ~hit_way;
				if (write_enable)
				begin
					dirty_q[index_in][hit_way] <= 1'b1;
				end
			end
			else if (dirty_miss)
			begin
				// victim goes out to memory, next lookup sees it clean
				dirty_q[index_in][victim] <= 1'b0;
			end
			else if (clean_miss)
			begin
				valid_q[index_in][victim] <= 1'b0;
				pending_q[index_in][victim] <= mem_response;
				fill_is_load_q[index_in][victim] <= read_enable;
				lru_q[index_in] <= ~victim;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		for (int s = 0; s < dcache_geom_pkg::SETS; s++)
		begin
			for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
			begin
				if (fill_hit[s][w])
				begin
					data_q[s][w] <= fill_is_load_q[s][w] ? load_data_in : write_data_in;
				end
			end
		end
		if (write_enable && hit)
		begin
			data_q[index_in][hit_way] <= write_data_in;
		end
		if (clean_miss)
		begin
			tag_q[index_in][victim] <= tag_in;
		end
		data_out <= read_data;
	end

	// strobes come from the controller
	assert property (@(posedge clock) disable iff (reset) !(read_enable && write_enable));

	// memory tags are unique among outstanding fills
	assert property (@(posedge clock) disable iff (reset) $onehot0(fill_hit));

endmodule

`default_nettype wire

// ==== design/dcache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_controller (
	input  wire logic                                  clock,
	input  wire logic                                  reset,
	input  wire logic                                  req,
	input  wire dcache_bus_pkg::cpu_req_t              cpu_req,
	input  wire logic                                  data_is_valid,
	input  wire logic                                  data_is_dirty,
	input  wire logic                                  data_is_miss,
	input  wire logic                                  cache_is_full,
	input  wire logic [dcache_geom_pkg::BLOCK_W-1:0]   store_data_out,
	input  wire logic [dcache_geom_pkg::TAG_W-1:0]     victim_tag,
	input  wire logic [dcache_geom_pkg::BLOCK_W-1:0]   data_out,
	input  wire dcache_bus_pkg::mem_tag_t              mem_response,
	input  wire dcache_bus_pkg::mem_tag_t              mem_tag,
	output logic                                       ack,
	output dcache_bus_pkg::cpu_resp_t                  cpu_resp,
	output logic                                       read_enable,
	output logic                                       write_enable,
	output logic [dcache_geom_pkg::INDEX_W-1:0]        index_out,
	output logic [dcache_geom_pkg::TAG_W-1:0]          tag_out,
	output logic [dcache_geom_pkg::BLOCK_W-1:0]        write_data_out,
	output dcache_bus_pkg::mem_cmd_t                   mem_cmd
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_RESPOND,
		S_WRITEBACK,
		S_FILL_WAIT,
		S_RELEASE
	} state_e;

	state_e                              state;
	dcache_bus_pkg::mem_tag_t            wait_tag;
	logic [dcache_geom_pkg::TAG_W-1:0]   wb_tag;
	logic [dcache_geom_pkg::BLOCK_W-1:0] wb_data;
	logic                                clean_miss;

	// request fields straight to the arrays, cpu_req is held stable
	assign index_out = cpu_req.addr[dcache_geom_pkg::INDEX_W-1:0];
	assign tag_out = cpu_req.addr[dcache_geom_pkg::ADDR_W-1:dcache_geom_pkg::INDEX_W];
	assign write_data_out = cpu_req.data;

	assign read_enable = (state == S_LOOKUP) && !cpu_req.write;
	assign write_enable = (state == S_LOOKUP) && cpu_req.write;
	assign ack = (state == S_RELEASE);

	assign clean_miss = (state == S_LOOKUP) && data_is_miss && !cache_is_full && !data_is_dirty;

	always_comb
	begin
		mem_cmd.kind = dcache_bus_pkg::MEM_NONE;
		mem_cmd.addr = '0;
		mem_cmd.data = '0;
		if (clean_miss)
		begin
			// load goes out in the lookup cycle so the arrays catch its tag
			mem_cmd.kind = dcache_bus_pkg::MEM_LOAD;
			mem_cmd.addr = cpu_req.addr;
		end
		else if (state == S_WRITEBACK)
		begin
			mem_cmd.kind = dcache_bus_pkg::MEM_STORE;
			mem_cmd.addr = {wb_tag, index_out};
			mem_cmd.data = wb_data;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			wait_tag <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (req)
					begin
						state <= S_LOOKUP;
					end
				end
				S_LOOKUP:
				begin
					if (data_is_valid)
					begin
						state <= S_RESPOND;
					end
					else if (cache_is_full)
					begin
						// one idle cycle, then look again
						state <= S_IDLE;
					end
					else if (data_is_dirty)
					begin
						state <= S_WRITEBACK;
					end
					else if (data_is_miss)
					begin
						wait_tag <= mem_response;
						state <= S_FILL_WAIT;
					end
				end
				S_WRITEBACK:
				begin
					state <= S_LOOKUP;
				end
				S_FILL_WAIT:
				begin
					if (mem_tag == wait_tag)
					begin
						wait_tag <= '0;
						state <= S_RESPOND;
					end
				end
				S_RESPOND:
				begin
					state <= S_RELEASE;
				end
				S_RELEASE:
				begin
					if (!req)
					begin
						state <= S_IDLE;
					end
				end
				default:
				begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if ((state == S_LOOKUP) && data_is_dirty)
		begin
			wb_tag <= victim_tag;
			wb_data <= store_data_out;
		end
		if (state == S_RESPOND)
		begin
			cpu_resp.data <= data_out;
		end
	end

	// four-phase release
	assert property (@(posedge clock) disable iff (reset) (ack && !req) |=> !ack);

endmodule

`default_nettype wire

// ==== design/tagged_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module tagged_memory (
	input  wire logic                                  clock,
	input  wire logic                                  reset,
	input  wire dcache_bus_pkg::mem_cmd_t              mem_cmd,
	output dcache_bus_pkg::mem_tag_t                   mem_response,
	output dcache_bus_pkg::mem_tag_t                   mem_tag,
	output logic [dcache_geom_pkg::BLOCK_W-1:0]        load_data
);

	logic [dcache_geom_pkg::BLOCK_W-1:0] blocks [1 << dcache_geom_pkg::ADDR_W];

	dcache_bus_pkg::mem_tag_t next_tag;

	// load completions in flight, stage 0 is the youngest
	dcache_bus_pkg::mem_tag_t [dcache_geom_pkg::MEM_LATENCY-1:0] pipe_tag;
	logic [dcache_geom_pkg::MEM_LATENCY-1:0][dcache_geom_pkg::BLOCK_W-1:0] pipe_data;

	logic accept;
	logic is_load;
	logic tag_busy;

	assign accept = (mem_cmd.kind != dcache_bus_pkg::MEM_NONE);
	assign is_load = (mem_cmd.kind == dcache_bus_pkg::MEM_LOAD);
	assign mem_response = accept ? next_tag : '0;

	assign mem_tag = pipe_tag[dcache_geom_pkg::MEM_LATENCY-1];
	assign load_data = pipe_data[dcache_geom_pkg::MEM_LATENCY-1];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < (1 << dcache_geom_pkg::ADDR_W); i++)
			begin
				blocks[i] <= '0;
			end
			next_tag <= dcache_bus_pkg::mem_tag_t'(1);
			pipe_tag <= '0;
		end
		else
		begin
			if (mem_cmd.kind == dcache_bus_pkg::MEM_STORE)
			begin
				blocks[mem_cmd.addr] <= mem_cmd.data;
			end
			if (accept)
			begin
				// wraps from 15 to 1, zero is never handed out
				next_tag <= (next_tag == '1) ? dcache_bus_pkg::mem_tag_t'(1) : next_tag + 1'b1;
			end
			pipe_tag <= {pipe_tag[dcache_geom_pkg::MEM_LATENCY-2:0],
				is_load ? next_tag : dcache_bus_pkg::mem_tag_t'(0)};
		end
	end

	// read at accept time, so a store before a load is seen
	always_ff @(posedge clock)
	begin
		pipe_data <= {pipe_data[dcache_geom_pkg::MEM_LATENCY-2:0], blocks[mem_cmd.addr]};
	end

	always_comb
	begin
		tag_busy = 1'b0;
		for (int i = 0; i < dcache_geom_pkg::MEM_LATENCY; i++)
		begin
			if ((pipe_tag[i] != '0) && (pipe_tag[i] == next_tag))
			begin
				tag_busy = 1'b1;
			end
		end
	end

	// a tag is not reissued while an older load with it is still in flight
	assert property (@(posedge clock) disable iff (reset) is_load |-> !tag_busy);

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
	input  wire logic                          clock,
	input  wire logic                          reset,
	input  wire logic                          req,
	input  wire dcache_bus_pkg::cpu_req_t      cpu_req,
	output logic                               ack,
	output dcache_bus_pkg::cpu_resp_t          cpu_resp
);

	logic                                read_enable;
	logic                                write_enable;
	logic [dcache_geom_pkg::INDEX_W-1:0] index;
	logic [dcache_geom_pkg::TAG_W-1:0]   tag;
	logic [dcache_geom_pkg::BLOCK_W-1:0] write_data;
	logic [dcache_geom_pkg::BLOCK_W-1:0] store_data;
	logic [dcache_geom_pkg::TAG_W-1:0]   victim_tag;
	logic [dcache_geom_pkg::BLOCK_W-1:0] data_out;
	logic                                data_is_valid;
	logic                                data_is_dirty;
	logic                                data_is_miss;
	logic                                cache_is_full;
	dcache_bus_pkg::mem_cmd_t            mem_cmd;
	dcache_bus_pkg::mem_tag_t            mem_response;
	dcache_bus_pkg::mem_tag_t            mem_tag;
	logic [dcache_geom_pkg::BLOCK_W-1:0] load_data;

	dcache_controller u_controller (
		.clock          (clock),
		.reset          (reset),
		.req            (req),
		.cpu_req        (cpu_req),
		.data_is_valid  (data_is_valid),
		.data_is_dirty  (data_is_dirty),
		.data_is_miss   (data_is_miss),
		.cache_is_full  (cache_is_full),
		.store_data_out (store_data),
		.victim_tag     (victim_tag),
		.data_out       (data_out),
		.mem_response   (mem_response),
		.mem_tag        (mem_tag),
		.ack            (ack),
		.cpu_resp       (cpu_resp),
		.read_enable    (read_enable),
		.write_enable   (write_enable),
		.index_out      (index),
		.tag_out        (tag),
		.write_data_out (write_data),
		.mem_cmd        (mem_cmd)
	);

	dcache_mem u_mem (
		.clock          (clock),
		.reset          (reset),
		.index_in       (index),
		.tag_in         (tag),
		.read_enable    (read_enable),
		.write_enable   (write_enable),
		.write_data_in  (write_data),
		.mem_response   (mem_response),
		.mem_tag        (mem_tag),
		.load_data_in   (load_data),
		.store_data_out (store_data),
		.victim_tag     (victim_tag),
		.data_is_valid  (data_is_valid),
		.data_is_dirty  (data_is_dirty),
		.data_is_miss   (data_is_miss),
		.cache_is_full  (cache_is_full),
		.data_out       (data_out)
	);

	tagged_memory u_memory (
		.clock        (clock),
		.reset        (reset),
		.mem_cmd      (mem_cmd),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.load_data    (load_data)
	);

endmodule

`default_nettype wire

// ==== testbench/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

	typedef enum logic [1:0] {
		LAT_HIT,
		LAT_MISS,
		LAT_ANY
	} lat_class_e;

	typedef struct packed {
		logic                                write;
		logic [dcache_geom_pkg::ADDR_W-1:0]  addr;
		logic [dcache_geom_pkg::BLOCK_W-1:0] data;
		logic                                random_data;
		lat_class_e                          expect_lat;
	} op_t;

	localparam int ACK_TIMEOUT = 100;

	logic                      clock;
	logic                      reset;
	logic                      req;
	dcache_bus_pkg::cpu_req_t  cpu_req;
	logic                      ack;
	dcache_bus_pkg::cpu_resp_t cpu_resp;

	op_t                                 ops[$];
	logic [dcache_geom_pkg::BLOCK_W-1:0] ref_mem [1 << dcache_geom_pkg::ADDR_W];
	logic [63:0]                         rng_state;

	// resident tags per set, lru points at the way to replace
	logic [dcache_geom_pkg::TAG_W-1:0]                           model_tag
		[dcache_geom_pkg::SETS][dcache_geom_pkg::WAYS];
	logic [dcache_geom_pkg::SETS-1:0][dcache_geom_pkg::WAYS-1:0] model_valid;
	logic [dcache_geom_pkg::SETS-1:0]                            model_lru;

	int value_errors;
	int latency_errors;
	int handshake_errors;
	int timeout_errors;

	dcache_top dut (
		.clock    (clock),
		.reset    (reset),
		.req      (req),
		.cpu_req  (cpu_req),
		.ack      (ack),
		.cpu_resp (cpu_resp)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [63:0] xorshift64();
		logic [63:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 7);
		x = x ^ (x << 17);
		rng_state = x;
		return x;
	endfunction

	// hit or miss under two-way LRU allocation, updates the tag model
	function automatic lat_class_e classify_access(input logic [dcache_geom_pkg::ADDR_W-1:0] addr);
		logic [dcache_geom_pkg::INDEX_W-1:0] index;
		logic [dcache_geom_pkg::TAG_W-1:0]   tag;
		logic                                hit;
		logic                                way;
		index = addr[dcache_geom_pkg::INDEX_W-1:0];
		tag = addr[dcache_geom_pkg::ADDR_W-1:dcache_geom_pkg::INDEX_W];
		hit = 1'b0;
		way = model_lru[index];
		for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
		begin
			if (!hit && model_valid[index][w] && (model_tag[index][w] == tag))
			begin
				hit = 1'b1;
				way = w[0];
			end
		end
		if (!hit)
		begin
			model_valid[index][way] = 1'b1;
			model_tag[index][way] = tag;
		end
		model_lru[index] = !way;
		return hit ? LAT_HIT : LAT_MISS;
	endfunction

	task automatic add_op(input logic write, input logic [dcache_geom_pkg::ADDR_W-1:0] addr,
		input logic [dcache_geom_pkg::BLOCK_W-1:0] data, input logic random_data,
		input lat_class_e expect_lat);
		op_t op;
		op.write = write;
		op.addr = addr;
		op.data = data;
		op.random_data = random_data;
		op.expect_lat = expect_lat;
		ops.push_back(op);
	endtask

	task automatic end_run();
		$display("errors: value %0d, latency %0d, handshake %0d, timeout %0d",
			value_errors, latency_errors, handshake_errors, timeout_errors);
		if (value_errors + latency_errors + handshake_errors + timeout_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	endtask

	task automatic check_resp(input logic [dcache_geom_pkg::ADDR_W-1:0] addr,
		input dcache_bus_pkg::cpu_resp_t got, input dcache_bus_pkg::cpu_resp_t exp);
		if (got !== exp)
		begin
			$display("ERROR %0t cpu_resp (block %03h): got %016h expected %016h",
				$time, addr, got.data, exp.data);
			value_errors++;
		end
	endtask

	task automatic check_latency(input logic [dcache_geom_pkg::ADDR_W-1:0] addr,
		input int got, input lat_class_e cls);
		logic ok;
		case (cls)
			LAT_HIT: ok = (got == 2);
			default: ok = (got >= dcache_geom_pkg::MEM_LATENCY + 2);
		endcase
		if (!ok)
		begin
			$display("ERROR %0t ack latency (block %03h): got %0d expected %s",
				$time, addr, got, cls == LAT_HIT ? "2" : "a miss latency");
			latency_errors++;
		end
	endtask

	task automatic check_release(input int got);
		if (got != 1)
		begin
			$display("ERROR %0t ack release delay: got %0d expected 1", $time, got);
			handshake_errors++;
		end
	endtask

	task automatic check_ack(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR %0t ack: got %b expected %b", $time, got, exp);
			handshake_errors++;
		end
	endtask

	// counts clock edges after the drive edge until ack reaches level
	task automatic wait_ack(input logic level, output int cycles);
		logic done;
		cycles = 0;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clock);
			if (ack === level)
			begin
				done = 1'b1;
			end
			else
			begin
				cycles++;
				if (cycles >= ACK_TIMEOUT)
				begin
					$display("ack did not %s within %0d cycles", level ? "rise" : "fall", cycles);
					timeout_errors++;
					end_run();
				end
			end
		end
	endtask

	task automatic run_op(input op_t op);
		dcache_bus_pkg::cpu_req_t  request;
		dcache_bus_pkg::cpu_resp_t expected;
		lat_class_e                model_lat;
		int                        edges;
		int                        release_edges;
		request.write = op.write;
		request.addr = op.addr;
		request.data = op.random_data ? xorshift64() : op.data;
		if (op.write)
			ref_mem[op.addr] = request.data;
		expected.data = ref_mem[op.addr];
		model_lat = classify_access(op.addr);

		@(posedge clock);
		req <= 1'b1;
		cpu_req <= request;
		wait_ack(1'b1, edges);
		check_resp(op.addr, cpu_resp, expected);
		// latency counts from the first edge that samples req
		check_latency(op.addr, edges - 1, (op.expect_lat == LAT_ANY) ? model_lat : op.expect_lat);

		@(posedge clock);
		req <= 1'b0;
		wait_ack(1'b0, release_edges);
		check_release(release_edges);
	endtask

	initial
	begin
		logic [63:0] r;
		reset = 1'b1;
		req = 1'b0;
		cpu_req = '0;
		rng_state = 64'd37209;
		value_errors = 0;
		latency_errors = 0;
		handshake_errors = 0;
		timeout_errors = 0;
		model_valid = '0;
		model_lru = '0;
		for (int i = 0; i < (1 << dcache_geom_pkg::ADDR_W); i++)
			ref_mem[i] = '0;

		// cold reads
		add_op(1'b0, 9'h011, '0, 1'b0, LAT_MISS);
		add_op(1'b0, 9'h1f7, '0, 1'b0, LAT_MISS);
		add_op(1'b0, 9'h011, '0, 1'b0, LAT_HIT);
		// write then read back
		add_op(1'b1, 9'h022, 64'h0123_4567_89ab_cdef, 1'b0, LAT_MISS);
		add_op(1'b0, 9'h022, '0, 1'b0, LAT_HIT);
		// set 4, two resident blocks then a third
		add_op(1'b1, 9'h00c, '0, 1'b1, LAT_MISS);
		add_op(1'b1, 9'h014, '0, 1'b1, LAT_MISS);
		add_op(1'b0, 9'h00c, '0, 1'b0, LAT_HIT);
		add_op(1'b0, 9'h014, '0, 1'b0, LAT_HIT);
		add_op(1'b0, 9'h00c, '0, 1'b0, LAT_HIT);
		add_op(1'b0, 9'h01c, '0, 1'b0, LAT_MISS);
		add_op(1'b0, 9'h00c, '0, 1'b0, LAT_HIT);
		add_op(1'b0, 9'h014, '0, 1'b0, LAT_MISS);
		// set 5, A B A C evicts B
		add_op(1'b1, 9'h025, 64'h0000_aaaa_0000_aaaa, 1'b0, LAT_MISS);
		add_op(1'b1, 9'h02d, 64'h0000_bbbb_0000_bbbb, 1'b0, LAT_MISS);
		add_op(1'b0, 9'h025, '0, 1'b0, LAT_HIT);
		add_op(1'b1, 9'h035, 64'h0000_cccc_0000_cccc, 1'b0, LAT_MISS);
		add_op(1'b0, 9'h025, '0, 1'b0, LAT_HIT);
		add_op(1'b0, 9'h02d, '0, 1'b0, LAT_MISS);
		// random traffic on sets 1 and 6, four tags each
		for (int i = 0; i < 40; i++)
		begin
			r = xorshift64();
			add_op(r[0], {6'd8 + 6'(r[3:2]), r[1] ? 3'd6 : 3'd1}, '0, r[0], LAT_ANY);
		end

		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_ack(ack, 1'b0);

		foreach (ops[i])
			run_op(ops[i]);
		end_run();
	end

endmodule

`default_nettype wire

// ==== dcache_top.f ====
design/dcache_geom_pkg.sv
design/dcache_bus_pkg.sv
design/dcache_mem.sv
design/dcache_controller.sv
design/tagged_memory.sv
design/dcache_top.sv
testbench/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - files:
      - design/dcache_geom_pkg.sv
      - design/dcache_bus_pkg.sv
      - design/dcache_mem.sv
      - design/dcache_controller.sv
      - design/tagged_memory.sv
      - design/dcache_top.sv
  - target: test
    files:
      - testbench/dcache_tb.sv
